// ==== common/cmac_pkg.sv ====
// lane counts, operand/product/accumulator widths and the packed vector types
// shared by the int16 dot-product engine
`default_nettype none

package cmac_pkg;

  // ==================================================
  // sizes
  // ==================================================
  localparam int LANES      = 32;  // multiply lanes per item
  localparam int OPND_W     = 16;  // data and weight width
  localparam int PROD_W     = 32;  // full signed product
  localparam int ACC_W      = 44;  // 37 bits needed for 32 terms, rest is headroom
  localparam int TREE_SPLIT = 4;   // partial sums held between tree stages

  // ==================================================
  // types
  // ==================================================
  // one signed operand
  typedef logic signed [OPND_W-1:0] opnd_t;

  // all lanes side by side, lane 0 in the low bits
  typedef logic [LANES*OPND_W-1:0] opnd_vec_t;

  // one signed lane product
  typedef logic signed [PROD_W-1:0] prod_t;

  // all lane products, lane 0 in the low bits
  typedef logic [LANES*PROD_W-1:0] prod_vec_t;

  // one signed sum
  typedef logic signed [ACC_W-1:0] acc_t;

  // partial sums between the two tree register stages
  typedef logic [TREE_SPLIT*ACC_W-1:0] psum_vec_t;

endpackage : cmac_pkg

`default_nettype wire

// ==== cmac/cmac_ctrl.sv ====
// pipeline control: operand join, valid shift chain, stage load enables, flush
`timescale 1ns/1ps
`default_nettype none

module cmac_ctrl (
  input  logic nvdla_core_clk,
  input  logic arst_n,
  input  logic dat_actv_pvld,
  input  logic wt_actv_pvld,
  input  logic cfg_flush,
  output logic prod_en,
  output logic psum_en,
  output logic out_en,
  output logic mac_out_pvld
);

  logic       accept;  // both operands present, no flush
  logic [2:0] vld_q;   // [0] product, [1] partial sums, [2] result

  // ==================================================
  // accept condition
  // ==================================================
  // a lone pvld on either side takes nothing
  assign accept = dat_actv_pvld & wt_actv_pvld & ~cfg_flush;

  // ==================================================
  // valid shift chain
  // ==================================================
  always_ff @(posedge nvdla_core_clk or negedge arst_n) begin
    if (!arst_n) begin
      vld_q <= '0;
    end else if (cfg_flush) begin
      vld_q <= '0;  // drop everything in flight
    end else begin
      vld_q <= {vld_q[1:0], accept};
    end
  end

  // ==================================================
  // stage enables
  // ==================================================
  // each data stage loads only when it takes over a live item,
  // so the result register holds between items and across a flush
  assign prod_en = accept;
  assign psum_en = vld_q[0] & ~cfg_flush;
  assign out_en  = vld_q[1] & ~cfg_flush;

  assign mac_out_pvld = vld_q[2];  // one pulse per item

endmodule : cmac_ctrl

`default_nettype wire

// ==== cmac/cmac_mult_array.sv ====
// signed 16x16 lane multipliers and the product register stage
`timescale 1ns/1ps
`default_nettype none

module cmac_mult_array
  import cmac_pkg::*;
(
  input  logic      nvdla_core_clk,
  input  logic      prod_en,
  input  opnd_vec_t dat_actv_data,
  input  opnd_vec_t wt_actv_data,
  output prod_vec_t prod_q
);

  prod_vec_t prod_d;  // products before the register

  // ==================================================
  // lane multipliers
  // ==================================================
  for (genvar i = 0; i < LANES; i++) begin : g_lane
    opnd_t dat;
    opnd_t wt;
    prod_t prod;

    assign dat  = dat_actv_data[i*OPND_W +: OPND_W];
    assign wt   = wt_actv_data[i*OPND_W +: OPND_W];
    assign prod = dat * wt;  // both signed, evaluated at 32 bits

    assign prod_d[i*PROD_W +: PROD_W] = prod;
  end

  // ==================================================
  // product register
  // ==================================================
  always_ff @(posedge nvdla_core_clk) begin
    if (prod_en) begin
      prod_q <= prod_d;  // load only for an accepted item
    end
  end

endmodule : cmac_mult_array

`default_nettype wire

// ==== cmac/cmac_adder_tree.sv ====
// sign extension and five-level adder tree, registered after level 3
// and after level 5
`timescale 1ns/1ps
`default_nettype none

module cmac_adder_tree
  import cmac_pkg::*;
(
  input  logic      nvdla_core_clk,
  input  logic      psum_en,
  input  logic      out_en,
  input  prod_vec_t prod_q,
  output acc_t      mac_out_data
);

  acc_t      ext  [LANES];         // products at full sum width
  acc_t      lvl1 [LANES/2];
  acc_t      lvl2 [LANES/4];
  acc_t      lvl3 [TREE_SPLIT];
  psum_vec_t psum_q;               // registered partial sums
  acc_t      lvl4 [TREE_SPLIT/2];
  acc_t      lvl5;

  // ==================================================
  // sign extension
  // ==================================================
  for (genvar i = 0; i < LANES; i++) begin : g_ext
    prod_t prod;

    assign prod   = prod_q[i*PROD_W +: PROD_W];
    assign ext[i] = {{(ACC_W-PROD_W){prod[PROD_W-1]}}, prod};
  end

  // ==================================================
  // levels 1 to 3, 32 terms down to 4
  // ==================================================
  for (genvar i = 0; i < LANES/2; i++) begin : g_l1
    assign lvl1[i] = ext[2*i] + ext[2*i+1];
  end

  for (genvar i = 0; i < LANES/4; i++) begin : g_l2
    assign lvl2[i] = lvl1[2*i] + lvl1[2*i+1];
  end

  for (genvar i = 0; i < TREE_SPLIT; i++) begin : g_l3
    assign lvl3[i] = lvl2[2*i] + lvl2[2*i+1];
  end

  // partial sum stage
  always_ff @(posedge nvdla_core_clk) begin
    if (psum_en) begin
      for (int j = 0; j < TREE_SPLIT; j++) begin
        psum_q[j*ACC_W +: ACC_W] <= lvl3[j];
      end
    end
  end

  // ==================================================
  // levels 4 and 5, 4 partial sums down to 1
  // ==================================================
  for (genvar i = 0; i < TREE_SPLIT/2; i++) begin : g_l4
    acc_t lo;
    acc_t hi;

    assign lo      = psum_q[(2*i)*ACC_W +: ACC_W];
    assign hi      = psum_q[(2*i+1)*ACC_W +: ACC_W];
    assign lvl4[i] = lo + hi;
  end

  assign lvl5 = lvl4[0] + lvl4[1];

  // result stage, holds between items
  always_ff @(posedge nvdla_core_clk) begin
    if (out_en) begin
      mac_out_data <= lvl5;
    end
  end

endmodule : cmac_adder_tree

`default_nettype wire

// ==== cmac/cmac_top.sv ====
// dot-product engine top: control plus multiplier array and adder tree
`timescale 1ns/1ps
`default_nettype none

module cmac_top
  import cmac_pkg::*;
(
  input  logic      nvdla_core_clk,
  input  logic      arst_n,
  input  opnd_vec_t dat_actv_data,
  input  logic      dat_actv_pvld,
  input  opnd_vec_t wt_actv_data,
  input  logic      wt_actv_pvld,
  input  logic      cfg_flush,
  output acc_t      mac_out_data,
  output logic      mac_out_pvld
);

  logic      prod_en;  // product stage load
  logic      psum_en;  // partial sum stage load
  logic      out_en;   // result stage load
  prod_vec_t prod_q;

  // ==================================================
  // control
  // ==================================================
  cmac_ctrl u_ctrl (
    .nvdla_core_clk (nvdla_core_clk),
    .arst_n         (arst_n),
    .dat_actv_pvld  (dat_actv_pvld),
    .wt_actv_pvld   (wt_actv_pvld),
    .cfg_flush      (cfg_flush),
    .prod_en        (prod_en),
    .psum_en        (psum_en),
    .out_en         (out_en),
    .mac_out_pvld   (mac_out_pvld)
  );

  // ==================================================
  // datapath
  // ==================================================
  cmac_mult_array u_mult (
    .nvdla_core_clk (nvdla_core_clk),
    .prod_en        (prod_en),
    .dat_actv_data  (dat_actv_data),
    .wt_actv_data   (wt_actv_data),
    .prod_q         (prod_q)
  );

  cmac_adder_tree u_tree (
    .nvdla_core_clk (nvdla_core_clk),
    .psum_en        (psum_en),
    .out_en         (out_en),
    .prod_q         (prod_q),
    .mac_out_data   (mac_out_data)
  );

endmodule : cmac_top

`default_nettype wire

// ==== bench/tb_cmac_util.svh ====
// testbench helpers: Galois LFSR, reference dot product and typed compare tasks
`ifndef TB_CMAC_UTIL_SVH
`define TB_CMAC_UTIL_SVH

// ==================================================
// random source
// ==================================================
localparam logic [31:0] LFSR_SEED = 32'hf965_a7ce;
localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;  // x^32 + x^22 + x^2 + x + 1

logic [31:0] lfsr_q = LFSR_SEED;

// one shift of the Galois register per bit handed out
function automatic logic lfsr_bit();
  logic out;
  out    = lfsr_q[0];
  lfsr_q = lfsr_q >> 1;
  if (out) begin
    lfsr_q = lfsr_q ^ LFSR_TAPS;  // feedback into the tap positions
  end
  return out;
endfunction

function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    v = {v[30:0], lfsr_bit()};
  end
  return v;
endfunction

function automatic opnd_vec_t rand_opnd();
  opnd_vec_t   v;
  logic [31:0] r;
  for (int i = 0; i < LANES; i++) begin
    r = rand_bits(OPND_W);
    v[i*OPND_W +: OPND_W] = r[OPND_W-1:0];
  end
  return v;
endfunction

// ==================================================
// reference model
// ==================================================
// plain running sum of lane products in 64 bits, cut to the result width
function automatic acc_t ref_dot(input opnd_vec_t d, input opnd_vec_t w);
  opnd_t  a;
  opnd_t  b;
  longint sum;
  sum = 0;
  for (int i = 0; i < LANES; i++) begin
    a   = d[i*OPND_W +: OPND_W];
    b   = w[i*OPND_W +: OPND_W];
    sum = sum + longint'(a) * longint'(b);
  end
  return sum[ACC_W-1:0];
endfunction

// ==================================================
// compare tasks
// ==================================================
task automatic check_acc(input string name, input acc_t got, input acc_t exp);
  if (got !== exp) begin
    data_errs++;
    $display("ERROR %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
  end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    flag_errs++;
    $display("ERROR %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
  end
endtask

`endif

// ==== bench/tb_cmac.sv ====
// testbench for the dot-product engine: clock, reset, stimulus, model queue,
// output checker, watchdog and summary
`timescale 1ns/1ps
`default_nettype none

module tb_cmac
  import cmac_pkg::*;
();

  localparam int    TEST_CYCLES    = 500;              // rough length of all tests
  localparam int    TIMEOUT_CYCLES = 4 * TEST_CYCLES;
  localparam opnd_t OPND_MIN       = 16'sh8000;
  localparam opnd_t OPND_MAX       = 16'sh7fff;

  logic      nvdla_core_clk;
  logic      arst_n;
  opnd_vec_t dat_actv_data;
  logic      dat_actv_pvld;
  opnd_vec_t wt_actv_data;
  logic      wt_actv_pvld;
  logic      cfg_flush;
  acc_t      mac_out_data;
  logic      mac_out_pvld;

  int         data_errs = 0;
  int         flag_errs = 0;
  int         misc_errs = 0;
  acc_t       exp_q[$];        // sums still owed by the DUT
  logic [2:0] exp_vld = '0;    // model of the three valid stages
  acc_t       last_data;
  logic       have_data = 1'b0;

  `include "tb_cmac_util.svh"

  cmac_top dut (
    .nvdla_core_clk (nvdla_core_clk),
    .arst_n         (arst_n),
    .dat_actv_data  (dat_actv_data),
    .dat_actv_pvld  (dat_actv_pvld),
    .wt_actv_data   (wt_actv_data),
    .wt_actv_pvld   (wt_actv_pvld),
    .cfg_flush      (cfg_flush),
    .mac_out_data   (mac_out_data),
    .mac_out_pvld   (mac_out_pvld)
  );

  initial begin
    nvdla_core_clk = 1'b0;
    forever #10 nvdla_core_clk = ~nvdla_core_clk;
  end

  function automatic opnd_vec_t splat(input opnd_t v);
    opnd_vec_t out;
    for (int i = 0; i < LANES; i++) begin
      out[i*OPND_W +: OPND_W] = v;
    end
    return out;
  endfunction

  function automatic opnd_vec_t alternate(input opnd_t even_v, input opnd_t odd_v);
    opnd_vec_t out;
    for (int i = 0; i < LANES; i++) begin
      out[i*OPND_W +: OPND_W] = (i % 2 == 0) ? even_v : odd_v;
    end
    return out;
  endfunction

  // ==================================================
  // one clock of stimulus plus the model update
  // ==================================================
  task automatic step(input logic dv, input logic wv, input logic fl,
                      input opnd_vec_t d, input opnd_vec_t w);
    logic take;
    @(negedge nvdla_core_clk);
    dat_actv_pvld = dv;
    wt_actv_pvld  = wv;
    cfg_flush     = fl;
    dat_actv_data = d;
    wt_actv_data  = w;
    take = dv & wv & ~fl;
    @(posedge nvdla_core_clk);
    if (fl) begin
      exp_vld = '0;     // in-flight items are gone
      exp_q.delete();
    end else begin
      exp_vld = {exp_vld[1:0], take};
      if (take) begin
        exp_q.push_back(ref_dot(d, w));
      end
    end
  endtask

  // ==================================================
  // output checker
  // ==================================================
  always @(negedge nvdla_core_clk) begin : compare_out
    acc_t exp_sum;
    check_bit("mac_out_pvld", mac_out_pvld, exp_vld[2]);
    if (mac_out_pvld) begin
      if (exp_q.size() == 0) begin
        misc_errs++;
        $display("result valid at %0t with nothing expected", $time);
      end else begin
        exp_sum = exp_q.pop_front();
        check_acc("mac_out_data", mac_out_data, exp_sum);
        last_data = exp_sum;  // result held until the next item
        have_data = 1'b1;
      end
    end else if (have_data) begin
      check_acc("mac_out_data", mac_out_data, last_data);  // must hold
    end
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge nvdla_core_clk);
      cycles++;
    end
    $display("run stopped after %0d cycles without finishing", cycles);
    $display("TESTS FAILED");
    $finish;
  end

  // ==================================================
  // test sequence
  // ==================================================
  initial begin : stimulus
    opnd_vec_t d;
    opnd_vec_t w;
    int        gap;
    int        burst;
    arst_n        = 1'b0;
    dat_actv_pvld = 1'b0;
    wt_actv_pvld  = 1'b0;
    cfg_flush     = 1'b0;
    dat_actv_data = '0;
    wt_actv_data  = '0;
    repeat (16) @(negedge nvdla_core_clk);
    arst_n = 1'b1;
    repeat (4) step(1'b0, 1'b0, 1'b0, '0, '0);  // valid stays low

    repeat (200) begin  // back to back
      d = rand_opnd();
      w = rand_opnd();
      step(1'b1, 1'b1, 1'b0, d, w);
    end

    step(1'b1, 1'b1, 1'b0, splat(OPND_MIN), splat(OPND_MIN));
    step(1'b1, 1'b1, 1'b0, splat(OPND_MIN), splat(OPND_MAX));
    step(1'b1, 1'b1, 1'b0, splat(OPND_MAX), splat(OPND_MAX));
    step(1'b1, 1'b1, 1'b0, alternate(OPND_MIN, OPND_MAX), splat(OPND_MIN));
    step(1'b1, 1'b1, 1'b0, alternate(OPND_MAX, OPND_MIN), alternate(OPND_MIN, OPND_MAX));

    repeat (40) begin  // lone valids and idle gaps
      step(1'b1, 1'b0, 1'b0, rand_opnd(), rand_opnd());
      step(1'b0, 1'b1, 1'b0, rand_opnd(), rand_opnd());
      gap = int'(rand_bits(2));
      repeat (gap) step(1'b0, 1'b0, 1'b0, rand_opnd(), rand_opnd());
      step(1'b1, 1'b1, 1'b0, rand_opnd(), rand_opnd());
    end

    repeat (12) begin  // flush with 1 to 4 items sent before it
      burst = int'(rand_bits(2)) + 1;
      repeat (burst) step(1'b1, 1'b1, 1'b0, rand_opnd(), rand_opnd());
      step(1'b1, 1'b1, 1'b1, rand_opnd(), rand_opnd());  // same-edge input dropped
      repeat (2) step(1'b1, 1'b1, 1'b0, rand_opnd(), rand_opnd());
      step(1'b0, 1'b0, 1'b0, rand_opnd(), rand_opnd());
    end

    repeat (6) step(1'b0, 1'b0, 1'b0, '0, '0);  // drain
    if (exp_q.size() != 0) begin
      misc_errs++;
      $display("%0d expected results never came out", exp_q.size());
    end
    $display("errors: data %0d, valid %0d, other %0d", data_errs, flag_errs, misc_errs);
    if (data_errs + flag_errs + misc_errs == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule : tb_cmac

`default_nettype wire

// ==== project.f ====
+incdir+bench
common/cmac_pkg.sv
cmac/cmac_ctrl.sv
cmac/cmac_mult_array.sv
cmac/cmac_adder_tree.sv
cmac/cmac_top.sv
bench/tb_cmac.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the testbench with Verilator, then decide from the log

cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing -Wno-fatal --top-module tb_cmac -f project.f \
  -o tb_cmac_sim > sim.log 2>&1 &&
  ./obj_dir/tb_cmac_sim 2>&1 | tee -a sim.log ||
  { echo "build or run failed, see sim.log"; exit 1; }

grep -q "^TESTS PASSED$" sim.log &&
  echo "simulation passed" ||
  { echo "simulation failed, see sim.log"; exit 1; }
